// ==== text_pkg.sv ====
package text_pkg;

	// screen geometry sized small for simulation
	localparam int H_ACTIVE = 64;
	localparam int H_FRONT  = 4;
	localparam int H_SYNC   = 8;
	localparam int H_BACK   = 4;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	localparam int V_ACTIVE = 32;
	localparam int V_FRONT  = 2;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 4;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam int GLYPH_W   = 8;
	localparam int GLYPH_H   = 8;
	localparam int TEXT_COLS = H_ACTIVE / GLYPH_W;
	localparam int TEXT_ROWS = V_ACTIVE / GLYPH_H;
	localparam int CELLS     = TEXT_COLS * TEXT_ROWS;

	// set-2 scan codes
	localparam logic [7:0] SC_BREAK = 8'hf0;
	localparam logic [7:0] SC_ENTER = 8'h5a;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} scan_t;

	typedef struct packed {
		logic       valid;
		logic       newline;
		logic [3:0] glyph;
	} char_cmd_t;

	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       active;
		logic [6:0] x;
		logic [5:0] y;
	} pix_pos_t;

	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       active;
		logic [6:0] x;
		logic [5:0] y;
		logic       pixel_on;
	} vga_out_t;

endpackage

// ==== ps2_receiver.sv ====
`timescale 1ns/10ps
module ps2_receiver (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            ps2_clk,
	input  logic            ps2_data,
	output text_pkg::scan_t scan,
	output logic [7:0]      parity_errors
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_prev;
	logic [9:0] shift;
	logic [3:0] bit_cnt;
	logic [7:0] byte_q;
	logic       byte_vld;
	logic       fall;
	logic       frame_ok;

	// both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// shift[0] start, shift[8:1] data, shift[9] parity; stop bit is still on the line
	assign frame_ok = ~shift[0] & data_sync[1] & (^shift[9:1]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt       <= 4'd0;
			byte_vld      <= 1'b0;
			parity_errors <= 8'd0;
		end else begin
			byte_vld <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= 4'd0;
					if (frame_ok) begin
						byte_vld <= 1'b1;
					end else if (parity_errors != 8'hff) begin
						parity_errors <= parity_errors + 8'd1;
					end
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// lsb first, so shift right
	always_ff @(posedge clk) begin
		if (fall) begin
			shift <= {data_sync[1], shift[9:1]};
		end
		if (fall && bit_cnt == 4'd10) begin
			byte_q <= shift[8:1];
		end
	end

	assign scan = '{valid: byte_vld, data: byte_q};

endmodule

// ==== scancode_to_ascii.sv ====
`timescale 1ns/10ps
module scancode_to_ascii (
	input  logic                clk,
	input  logic                rst_n,
	input  text_pkg::scan_t     scan,
	output text_pkg::char_cmd_t cmd
);

	logic       brk;
	logic       hit;
	logic       nl;
	logic [3:0] glyph;
	logic       cmd_vld;
	logic       cmd_nl;
	logic [3:0] cmd_glyph;

	// make codes for the hex digits and enter
	always_comb begin
		hit   = 1'b1;
		nl    = 1'b0;
		glyph = 4'h0;
		case (scan.data)
			8'h45: glyph = 4'h0;
			8'h16: glyph = 4'h1;
			8'h1e: glyph = 4'h2;
			8'h26: glyph = 4'h3;
			8'h25: glyph = 4'h4;
			8'h2e: glyph = 4'h5;
			8'h36: glyph = 4'h6;
			8'h3d: glyph = 4'h7;
			8'h3e: glyph = 4'h8;
			8'h46: glyph = 4'h9;
			8'h1c: glyph = 4'ha;
			8'h32: glyph = 4'hb;
			8'h21: glyph = 4'hc;
			8'h23: glyph = 4'hd;
			8'h24: glyph = 4'he;
			8'h2b: glyph = 4'hf;
			text_pkg::SC_ENTER: nl = 1'b1;
			default: hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			brk     <= 1'b0;
			cmd_vld <= 1'b0;
		end else begin
			cmd_vld <= 1'b0;
			if (scan.valid) begin
				if (scan.data == text_pkg::SC_BREAK) begin
					brk <= 1'b1;
				end else if (brk) begin
					// swallow the released key
					brk <= 1'b0;
				end else begin
					cmd_vld <= hit;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (scan.valid) begin
			cmd_nl    <= nl;
			cmd_glyph <= glyph;
		end
	end

	assign cmd = '{valid: cmd_vld, newline: cmd_nl, glyph: cmd_glyph};

endmodule

// ==== vga_timing.sv ====
`timescale 1ns/10ps
module vga_timing (
	input  logic               clk,
	input  logic               rst_n,
	output text_pkg::pix_pos_t pos
);

	logic [6:0] h_nxt;
	logic [5:0] v_nxt;
	logic       h_wrap;
	logic       hs_nxt;
	logic       vs_nxt;
	logic       act_nxt;

	// pos.x and pos.y are the counters themselves
	assign h_wrap = (pos.x == 7'(text_pkg::H_TOTAL - 1));
	assign h_nxt  = h_wrap ? 7'd0 : pos.x + 7'd1;

	always_comb begin
		v_nxt = pos.y;
		if (h_wrap) begin
			if (pos.y == 6'(text_pkg::V_TOTAL - 1)) begin
				v_nxt = 6'd0;
			end else begin
				v_nxt = pos.y + 6'd1;
			end
		end
	end

	// sync pulses are active low, right after the front porch
	assign hs_nxt = !(h_nxt >= 7'(text_pkg::H_ACTIVE + text_pkg::H_FRONT) &&
		h_nxt < 7'(text_pkg::H_ACTIVE + text_pkg::H_FRONT + text_pkg::H_SYNC));
	assign vs_nxt = !(v_nxt >= 6'(text_pkg::V_ACTIVE + text_pkg::V_FRONT) &&
		v_nxt < 6'(text_pkg::V_ACTIVE + text_pkg::V_FRONT + text_pkg::V_SYNC));
	assign act_nxt = (h_nxt < 7'(text_pkg::H_ACTIVE)) && (v_nxt < 6'(text_pkg::V_ACTIVE));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b1, x: 7'd0, y: 6'd0};
		end else begin
			pos <= '{hsync: hs_nxt, vsync: vs_nxt, active: act_nxt, x: h_nxt, y: v_nxt};
		end
	end

endmodule

// ==== char_buffer.sv ====
`timescale 1ns/10ps
module char_buffer (
	input  logic                clk,
	input  logic                rst_n,
	input  text_pkg::char_cmd_t cmd,
	input  text_pkg::pix_pos_t  pos,
	output text_pkg::vga_out_t  vga
);

	typedef logic [$clog2(text_pkg::TEXT_COLS)-1:0] col_t;
	typedef logic [$clog2(text_pkg::TEXT_ROWS)-1:0] row_t;
	typedef logic [$clog2(text_pkg::CELLS)-1:0] idx_t;
	typedef logic [text_pkg::GLYPH_W*text_pkg::GLYPH_H-1:0] glyph_word_t;

	col_t                     cur_col;
	row_t                     cur_row;
	logic [text_pkg::CELLS-1:0] used;
	logic [3:0]               glyph_mem [text_pkg::CELLS];
	glyph_word_t              font_rom [16];

	col_t        cell_col;
	row_t        cell_row;
	idx_t        cell_idx;
	logic [2:0]  g_row;
	logic [2:0]  g_col;
	glyph_word_t glyph_bits;
	logic        pix;

	initial begin
		$readmemh("font.hex", font_rom);
	end

	// the cursor wraps from the last row back to row 0 and overwrites
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_col <= '0;
			cur_row <= '0;
			used    <= '0;
		end else if (cmd.valid) begin
			if (!cmd.newline) begin
				used[{cur_row, cur_col}] <= 1'b1;
			end
			if (cmd.newline || cur_col == col_t'(text_pkg::TEXT_COLS - 1)) begin
				cur_col <= '0;
				cur_row <= cur_row + row_t'(1);
			end else begin
				cur_col <= cur_col + col_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.valid && !cmd.newline) begin
			glyph_mem[{cur_row, cur_col}] <= cmd.glyph;
		end
	end

	// cell lookup for the current scan position
	assign cell_col   = col_t'(pos.x / 7'(text_pkg::GLYPH_W));
	assign cell_row   = row_t'(pos.y / 6'(text_pkg::GLYPH_H));
	assign cell_idx   = {cell_row, cell_col};
	assign g_col      = 3'(pos.x % 7'(text_pkg::GLYPH_W));
	assign g_row      = 3'(pos.y % 6'(text_pkg::GLYPH_H));
	assign glyph_bits = font_rom[glyph_mem[cell_idx]];

	// row 0 in the top byte, bit 7 leftmost, so index is 63 - 8*row - col
	assign pix = pos.active & used[cell_idx] & glyph_bits[~{g_row, g_col}];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vga <= '{hsync: 1'b1, vsync: 1'b1, default: '0};
		end else begin
			vga <= '{
				hsync:    pos.hsync,
				vsync:    pos.vsync,
				active:   pos.active,
				x:        pos.x,
				y:        pos.y,
				pixel_on: pix
			};
		end
	end

endmodule

// ==== text_display_top.sv ====
`timescale 1ns/10ps
module text_display_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ps2_clk,
	input  logic               ps2_data,
	output text_pkg::vga_out_t vga,
	output logic [7:0]         parity_errors
);

	text_pkg::scan_t     scan;
	text_pkg::char_cmd_t cmd;
	text_pkg::pix_pos_t  pos;

	ps2_receiver u_ps2 (
		.clk           (clk),
		.rst_n         (rst_n),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.scan          (scan),
		.parity_errors (parity_errors)
	);

	scancode_to_ascii u_xlate (
		.clk   (clk),
		.rst_n (rst_n),
		.scan  (scan),
		.cmd   (cmd)
	);

	vga_timing u_timing (
		.clk   (clk),
		.rst_n (rst_n),
		.pos   (pos)
	);

	char_buffer u_buf (
		.clk   (clk),
		.rst_n (rst_n),
		.cmd   (cmd),
		.pos   (pos),
		.vga   (vga)
	);

endmodule

// ==== text_display_chk.sv ====
`timescale 1ns/10ps
module text_display_chk (
	input logic               clk,
	input logic               rst_n,
	input text_pkg::vga_out_t vga,
	input logic [7:0]         parity_errors
);

	int hs_len;
	int vs_len;
	int hs_fails = 0;
	int vs_fails = 0;
	int cnt_fails = 0;

	// length of the current low run of each sync
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hs_len <= 0;
			vs_len <= 0;
		end else begin
			hs_len <= vga.hsync ? 0 : hs_len + 1;
			vs_len <= vga.vsync ? 0 : vs_len + 1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(vga.hsync) |-> hs_len == text_pkg::H_SYNC)
	else begin
		$error("hsync pulse has the wrong width");
		hs_fails++;
	end

	// vsync spans whole lines
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(vga.vsync) |-> vs_len == text_pkg::V_SYNC * text_pkg::H_TOTAL)
	else begin
		$error("vsync pulse has the wrong width");
		vs_fails++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		parity_errors >= $past(parity_errors))
	else begin
		$error("parity error count went down");
		cnt_fails++;
	end

endmodule

bind text_display_top text_display_chk chk (
	.clk           (clk),
	.rst_n         (rst_n),
	.vga           (vga),
	.parity_errors (parity_errors)
);

// ==== tb_text_display.sv ====
`timescale 1ns/10ps
module tb_text_display;

	localparam int CLK_NS       = 8;
	localparam int BIT_CLKS     = 16;
	localparam int FRAME_CLKS   = text_pkg::H_TOTAL * text_pkg::V_TOTAL;
	localparam int PS2_FRAMES   = 140;
	localparam int CHECK_FRAMES = 20;
	localparam int MARGIN_CLKS  = 10000;
	localparam int WATCHDOG_NS  =
		(PS2_FRAMES * 11 * BIT_CLKS + CHECK_FRAMES * FRAME_CLKS + MARGIN_CLKS) * CLK_NS;

	logic               clk;
	logic               rst_n;
	logic               ps2_clk;
	logic               ps2_data;
	text_pkg::vga_out_t vga;
	logic [7:0]         parity_errors;

	logic [63:0] font [16];
	logic [7:0]  key_code [16];
	logic        model_used [text_pkg::CELLS];
	logic [3:0]  model_glyph [text_pkg::CELLS];
	int          cur_col;
	int          cur_row;
	int          exp_parity;
	int          pixel_errs;
	int          count_errs;
	int          other_errs;
	int          seed = 41566;

	text_display_top uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.vga           (vga),
		.parity_errors (parity_errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// leaves the caller 1 ns after a rising edge
	task automatic idle_clocks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		logic [10:0] bits;
		logic        par;
		int          i;
		// odd parity over data plus parity bit
		par = ~^data;
		if (bad_parity) begin
			par = ~par;
		end
		bits = {1'b1, par, data, 1'b0};
		for (i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			idle_clocks(BIT_CLKS / 2);
			ps2_clk = 1'b0;
			idle_clocks(BIT_CLKS / 2);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		idle_clocks(BIT_CLKS);
	endtask

	// make, then the break sequence
	task automatic press_key(input logic [7:0] code);
		send_frame(code, 1'b0);
		send_frame(text_pkg::SC_BREAK, 1'b0);
		send_frame(code, 1'b0);
	endtask

	function automatic void advance_line();
		cur_col = 0;
		cur_row = (cur_row + 1) % text_pkg::TEXT_ROWS;
	endfunction

	function automatic void store_glyph(input logic [3:0] g);
		logic [4:0] idx;
		idx = 5'(cur_row * text_pkg::TEXT_COLS + cur_col);
		model_used[idx] = 1'b1;
		model_glyph[idx] = g;
		if (cur_col == text_pkg::TEXT_COLS - 1) begin
			advance_line();
		end else begin
			cur_col++;
		end
	endfunction

	task automatic type_glyph(input logic [3:0] g);
		press_key(key_code[g]);
		store_glyph(g);
	endtask

	task automatic type_enter();
		press_key(text_pkg::SC_ENTER);
		advance_line();
	endtask

	function automatic text_pkg::vga_out_t expected_at(input int x, input int y);
		text_pkg::vga_out_t e;
		logic [4:0]         idx;
		logic [5:0]         bit_idx;
		e.hsync = !(x >= text_pkg::H_ACTIVE + text_pkg::H_FRONT &&
			x < text_pkg::H_ACTIVE + text_pkg::H_FRONT + text_pkg::H_SYNC);
		e.vsync = !(y >= text_pkg::V_ACTIVE + text_pkg::V_FRONT &&
			y < text_pkg::V_ACTIVE + text_pkg::V_FRONT + text_pkg::V_SYNC);
		e.active = (x < text_pkg::H_ACTIVE) && (y < text_pkg::V_ACTIVE);
		e.x = 7'(x);
		e.y = 6'(y);
		e.pixel_on = 1'b0;
		if (e.active) begin
			idx = 5'((y / text_pkg::GLYPH_H) * text_pkg::TEXT_COLS + x / text_pkg::GLYPH_W);
			bit_idx = 6'(text_pkg::GLYPH_W * text_pkg::GLYPH_H - 1 -
				text_pkg::GLYPH_W * (y % text_pkg::GLYPH_H) - x % text_pkg::GLYPH_W);
			if (model_used[idx]) begin
				e.pixel_on = font[model_glyph[idx]][bit_idx];
			end
		end
		return e;
	endfunction

	task automatic check_pixel(input text_pkg::vga_out_t exp, input text_pkg::vga_out_t got);
		if (got !== exp) begin
			$display("ERR %0t vga at x=%0d y=%0d: expected %h, got %h",
				$time, exp.x, exp.y, exp, got);
			pixel_errs++;
		end
	endtask

	task automatic check_errors(input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			$display("ERR %0t parity_errors: expected %0d, got %0d", $time, exp, got);
			count_errs++;
		end
	endtask

	// finish the current frame, then compare every position of the next one
	task automatic scan_frame();
		int wait_cnt;
		int x;
		int y;
		wait_cnt = 0;
		@(negedge clk);
		while (!(int'(vga.x) == text_pkg::H_TOTAL - 1 && int'(vga.y) == text_pkg::V_TOTAL - 1)
			&& wait_cnt < 2 * FRAME_CLKS) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (wait_cnt >= 2 * FRAME_CLKS) begin
			$display("timed out waiting for the end of a VGA frame");
			other_errs++;
		end else begin
			for (y = 0; y < text_pkg::V_TOTAL; y++) begin
				for (x = 0; x < text_pkg::H_TOTAL; x++) begin
					@(negedge clk);
					check_pixel(expected_at(x, y), vga);
				end
			end
		end
		idle_clocks(1);
	endtask

	task automatic blank_after_reset();
		scan_frame();
		check_errors(8'(exp_parity), parity_errors);
	endtask

	task automatic fill_first_row();
		int g;
		for (g = 0; g < 8; g++) begin
			type_glyph(4'(g));
		end
		scan_frame();
	endtask

	task automatic wrap_and_enter();
		type_glyph(4'h8);
		type_glyph(4'h9);
		type_glyph(4'ha);
		scan_frame();
		type_enter();
		type_glyph(4'hb);
		type_glyph(4'hc);
		scan_frame();
		// row 3, then past it back onto row 0
		type_enter();
		type_enter();
		type_glyph(4'hd);
		type_glyph(4'he);
		scan_frame();
	endtask

	task automatic break_and_unmapped();
		type_glyph(4'hf);
		// Z key is not in the character set
		press_key(8'h1a);
		scan_frame();
	endtask

	task automatic bad_parity_frame();
		send_frame(key_code[5], 1'b1);
		exp_parity++;
		scan_frame();
		check_errors(8'(exp_parity), parity_errors);
		type_glyph(4'h5);
		scan_frame();
		check_errors(8'(exp_parity), parity_errors);
	endtask

	task automatic random_keys();
		int n;
		int r;
		for (n = 0; n < 20; n++) begin
			r = int'($unsigned($random(seed)) % 17);
			if (r == 16) begin
				type_enter();
			end else begin
				type_glyph(4'(r));
			end
			if (n == 9 || n == 19) begin
				scan_frame();
			end
		end
		check_errors(8'(exp_parity), parity_errors);
	endtask

	initial begin
		int asrt_errs;
		rst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		pixel_errs = 0;
		count_errs = 0;
		other_errs = 0;
		exp_parity = 0;
		cur_col = 0;
		cur_row = 0;
		model_used = '{default: 1'b0};
		model_glyph = '{default: 4'h0};
		$readmemh("font.hex", font);
		// set-2 make codes of 0..9 and A..F
		key_code = '{8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d,
			8'h3e, 8'h46, 8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b};
		idle_clocks(4);
		rst_n = 1'b1;
		blank_after_reset();
		fill_first_row();
		wrap_and_enter();
		break_and_unmapped();
		bad_parity_frame();
		random_keys();
		asrt_errs = uut.chk.hs_fails + uut.chk.vs_fails + uut.chk.cnt_fails;
		$display("errors: pixel %0d, parity count %0d, other %0d, assertion %0d",
			pixel_errs, count_errs, other_errs, asrt_errs);
		if (pixel_errs + count_errs + other_errs + asrt_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== font.hex ====
// one 64-bit glyph per line for 0 to F
// row 0 in the top byte, bit 7 of each byte is the leftmost pixel
3c666e7666663c00
1838181818187e00
3c66060c30607e00
3c66061c06663c00
0c1c3c6c7e0c0c00
7e607c0606663c00
3c607c6666663c00
7e060c1830303000
3c66663c66663c00
3c66663e060c3800
183c66667e666600
7c66667c66667c00
3c66606060663c00
786c6666666c7800
7e60607860607e00
7e60607860606000

// ==== sim.f ====
text_pkg.sv
ps2_receiver.sv
scancode_to_ascii.sv
vga_timing.sv
char_buffer.sv
text_display_top.sv
text_display_chk.sv
tb_text_display.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_text_display -f sim.f -o sim_tb

# the log decides pass or fail
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "STATUS: PASS" sim.log
